// File: include/memgame_params.svh
`ifndef MEMGAME_PARAMS_SVH
`define MEMGAME_PARAMS_SVH

// character grid, 32x32 cells
`define MEMGAME_GRID_BITS 5
`define MEMGAME_CHAR_BITS 7

// text columns 0 to 16 are the only ones with content
`define MEMGAME_TEXT_COLS 17

// highscore table
`define MEMGAME_HS_NUM 5
`define MEMGAME_SCORE_BITS 14

// fields of a finished game
`define MEMGAME_PAIRS_BITS 8
`define MEMGAME_SEC_BITS 6
`define MEMGAME_HUND_BITS 7

// one decimal digit
`define MEMGAME_DIGIT_BITS 4

// ascii bases
`define MEMGAME_ASCII_ZERO 48
`define MEMGAME_ASCII_SPACE 32

`endif

// File: rtl/memgame_pkg.sv
`include "memgame_params.svh"

package memgame_pkg;

    ////////////////////////////////////////
    // grid and character types
    ////////////////////////////////////////

    typedef logic [`MEMGAME_GRID_BITS-1:0] grid_idx_t;

    typedef struct packed {
        grid_idx_t row;
        grid_idx_t col;
    } char_pos_t;

    typedef logic [`MEMGAME_CHAR_BITS-1:0] char_code_t;

    typedef struct packed {
        logic [`MEMGAME_PAIRS_BITS-1:0] pairs;
        logic [`MEMGAME_SEC_BITS-1:0]   seconds;
        logic [`MEMGAME_HUND_BITS-1:0]  hundredths;
    } game_result_t;

    // entry 0 holds the best score
    typedef logic [`MEMGAME_SCORE_BITS-1:0] score_t;
    typedef score_t [`MEMGAME_HS_NUM-1:0] score_table_t;

    typedef logic [`MEMGAME_DIGIT_BITS-1:0] digit_t;

    typedef struct packed {
        digit_t tens;
        digit_t units;
    } dec2_t;

    typedef struct packed {
        digit_t thousands;
        digit_t hundreds;
        digit_t tens;
        digit_t units;
    } dec4_t;

    ////////////////////////////////////////
    // text rows
    ////////////////////////////////////////

    // column 0 sits in the top byte
    typedef logic [8*`MEMGAME_TEXT_COLS-1:0] text_row_t;
    typedef logic [7:0] text_byte_t;

    function automatic text_byte_t digit_byte(input digit_t d);
        return text_byte_t'(`MEMGAME_ASCII_ZERO) + text_byte_t'(d);
    endfunction

    // a space in the row text is a blank cell, code 0
    function automatic char_code_t row_char(input text_row_t text, input grid_idx_t col);
        text_byte_t b;
        char_code_t code;
        b = text_byte_t'(`MEMGAME_ASCII_SPACE);
        code = '0;
        if (col < `MEMGAME_TEXT_COLS) begin
            b = text[8*(`MEMGAME_TEXT_COLS-1-col) +: 8];
        end
        if (b != text_byte_t'(`MEMGAME_ASCII_SPACE)) begin
            code = b[`MEMGAME_CHAR_BITS-1:0];
        end
        return code;
    endfunction

endpackage

// File: rtl/highscore_table.sv
`timescale 1ns/1ps

`include "memgame_params.svh"

module highscore_table (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            game_done,
    input  logic [`MEMGAME_PAIRS_BITS-1:0]  pairs,
    output memgame_pkg::score_table_t       score_table
);

    import memgame_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_NEW_RECORD,
        ST_WAIT_NEW_GAME
    } hs_state_t;

    hs_state_t state;
    hs_state_t state_nxt;

    score_t       new_score;
    score_table_t shifted;
    score_table_t table_nxt;

    // beats: new score strictly above the entry
    logic [`MEMGAME_HS_NUM-1:0] beats;
    logic [`MEMGAME_HS_NUM-1:0] lead;

    ////////////////////////////////////////
    // sorted insertion
    ////////////////////////////////////////

    assign new_score = {{(`MEMGAME_SCORE_BITS-`MEMGAME_PAIRS_BITS){1'b0}}, pairs};

    // every entry one slot lower, new score in slot 0
    assign shifted = {score_table[`MEMGAME_HS_NUM-2:0], new_score};

    always_comb begin
        for (int i = 0; i < `MEMGAME_HS_NUM; i++) begin
            beats[i] = new_score > score_table[i];
        end

        // table is sorted, so beats is set from some entry down to the last;
        // lead marks the first of them, where the new score lands
        lead = beats & ~(beats << 1);

        for (int i = 0; i < `MEMGAME_HS_NUM; i++) begin
            if (lead[i]) begin
                table_nxt[i] = new_score;
            end else if (beats[i]) begin
                table_nxt[i] = shifted[i];
            end else begin
                table_nxt[i] = score_table[i];
            end
        end
    end

    ////////////////////////////////////////
    // game FSM
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (game_done) begin
                    state_nxt = ST_NEW_RECORD;
                end
            end
            ST_NEW_RECORD: begin
                state_nxt = ST_WAIT_NEW_GAME;
            end
            ST_WAIT_NEW_GAME: begin
                // one insertion per game, hold until game_done drops
                if (!game_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            score_table <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_NEW_RECORD) begin
                score_table <= table_nxt;
            end
        end
    end

endmodule

// File: rtl/status_text.sv
`timescale 1ns/1ps

`include "memgame_params.svh"

module status_text (
    input  memgame_pkg::char_pos_t    pos,
    input  logic                      game_over,
    input  memgame_pkg::game_result_t result,
    output memgame_pkg::char_code_t   status_code
);

    import memgame_pkg::*;

    typedef logic [`MEMGAME_PAIRS_BITS-1:0] small_val_t;

    localparam grid_idx_t ROW_HEADER = grid_idx_t'(0);
    localparam grid_idx_t ROW_SCORE  = grid_idx_t'(2);
    localparam grid_idx_t ROW_TIME   = grid_idx_t'(4);

    dec2_t     pairs_dec;
    dec2_t     sec_dec;
    dec2_t     hund_dec;
    text_row_t row_text;

    function automatic dec2_t to_dec2(input small_val_t value);
        dec2_t d;
        d.tens  = digit_t'((value / 10) % 10);
        d.units = digit_t'(value % 10);
        return d;
    endfunction

    ////////////////////////////////////////
    // result digits
    ////////////////////////////////////////

    assign pairs_dec = to_dec2(result.pairs);
    assign sec_dec   = to_dec2(small_val_t'(result.seconds));
    assign hund_dec  = to_dec2(small_val_t'(result.hundredths));

    ////////////////////////////////////////
    // row templates
    ////////////////////////////////////////

    always_comb begin
        case (pos.row)
            ROW_HEADER: begin
                if (game_over) begin
                    row_text = "   GAME OVER!    ";
                end else begin
                    row_text = " Congratulations!";
                end
            end
            ROW_SCORE: begin
                // no score shown once the game is lost
                if (game_over) begin
                    row_text = " Your score: 0000";
                end else begin
                    row_text = {
                        " Your score: 00",
                        digit_byte(pairs_dec.tens),
                        digit_byte(pairs_dec.units)
                    };
                end
            end
            ROW_TIME: begin
                if (game_over) begin
                    row_text = " Your time passed";
                end else begin
                    // ss.hh
                    row_text = {
                        " Your time: ",
                        digit_byte(sec_dec.tens),
                        digit_byte(sec_dec.units),
                        ".",
                        digit_byte(hund_dec.tens),
                        digit_byte(hund_dec.units)
                    };
                end
            end
            default: begin
                row_text = '0;
            end
        endcase
    end

    assign status_code = row_char(row_text, pos.col);

endmodule

// File: rtl/score_board_text.sv
`timescale 1ns/1ps

`include "memgame_params.svh"

module score_board_text (
    input  memgame_pkg::char_pos_t    pos,
    input  memgame_pkg::score_table_t score_table,
    output memgame_pkg::char_code_t   board_code
);

    import memgame_pkg::*;

    localparam grid_idx_t ROW_TITLE = grid_idx_t'(14);
    localparam grid_idx_t ROW_FIRST = grid_idx_t'(16);

    grid_idx_t entry_idx;
    logic      in_table;
    digit_t    rank;
    score_t    entry_score;
    dec4_t     entry_dec;
    text_row_t row_text;

    function automatic dec4_t to_dec4(input score_t value);
        dec4_t d;
        d.thousands = digit_t'((value / 1000) % 10);
        d.hundreds  = digit_t'((value / 100) % 10);
        d.tens      = digit_t'((value / 10) % 10);
        d.units     = digit_t'(value % 10);
        return d;
    endfunction

    ////////////////////////////////////////
    // entry select
    ////////////////////////////////////////

    // rows above the table wrap to large indices and match no entry
    assign entry_idx = pos.row - ROW_FIRST;

    always_comb begin
        in_table    = 1'b0;
        rank        = '0;
        entry_score = '0;
        for (int i = 0; i < `MEMGAME_HS_NUM; i++) begin
            if (entry_idx == grid_idx_t'(i)) begin
                in_table    = 1'b1;
                rank        = digit_t'(i + 1);
                entry_score = score_table[i];
            end
        end
    end

    assign entry_dec = to_dec4(entry_score);

    ////////////////////////////////////////
    // row templates
    ////////////////////////////////////////

    always_comb begin
        if (pos.row == ROW_TITLE) begin
            row_text = "   Highscores    ";
        end else if (in_table) begin
            row_text = {
                " ",
                digit_byte(rank),
                ". ",
                digit_byte(entry_dec.thousands),
                digit_byte(entry_dec.hundreds),
                digit_byte(entry_dec.tens),
                digit_byte(entry_dec.units),
                " points  "
            };
        end else begin
            row_text = '0;
        end
    end

    assign board_code = row_char(row_text, pos.col);

endmodule

// File: rtl/screen_char_rom.sv
`timescale 1ns/1ps

`include "memgame_params.svh"

module screen_char_rom (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      game_done,
    input  logic                      game_over,
    input  memgame_pkg::game_result_t result,
    input  memgame_pkg::char_pos_t    pos,
    output memgame_pkg::char_code_t   char_code
);

    import memgame_pkg::*;

    score_table_t score_table;
    char_code_t   status_code;
    char_code_t   board_code;

    ////////////////////////////////////////
    // text sources
    ////////////////////////////////////////

    highscore_table highscore_table_i (
        .clk         (clk),
        .rst         (rst),
        .game_done   (game_done),
        .pairs       (result.pairs),
        .score_table (score_table)
    );

    status_text status_text_i (
        .pos         (pos),
        .game_over   (game_over),
        .result      (result),
        .status_code (status_code)
    );

    score_board_text score_board_text_i (
        .pos         (pos),
        .score_table (score_table),
        .board_code  (board_code)
    );

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    // rows of the two sources never overlap, each is 0 elsewhere
    always_ff @(posedge clk) begin
        if (rst) begin
            char_code <= '0;
        end else begin
            char_code <= status_code | board_code;
        end
    end

endmodule

// File: tests/tb_screen_char_rom.sv
`timescale 1ns/1ps

`include "memgame_params.svh"

module tb_screen_char_rom;

    import memgame_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int LCG_SEED     = 5659;

    localparam int N_RANDOM     = 10;
    localparam int N_OVER       = 3;
    localparam int N_GAMES      = 8;
    localparam int STATUS_CELLS = 3 * `MEMGAME_TEXT_COLS;
    localparam int BOARD_CELLS  = 6 * `MEMGAME_TEXT_COLS;
    localparam int BLANK_CELLS  = 5 * 32 + 6 * 15;
    localparam int READS        = BOARD_CELLS * (N_GAMES + 3)
                                + STATUS_CELLS * (N_RANDOM + N_OVER) + BLANK_CELLS;
    localparam int GAME_CYCLES  = 3 * (N_GAMES + 1) + 12;
    localparam int MARGIN       = 200;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + READS + GAME_CYCLES + MARGIN) * CLK_PERIOD;

    logic         clk;
    logic         rst;
    logic         game_done;
    logic         game_over;
    game_result_t result;
    char_pos_t    pos;
    char_code_t   char_code;

    // expected highscore list with entry 0 the best
    int          hs_model [0:`MEMGAME_HS_NUM-1];
    logic [31:0] lcg_state;

    screen_char_rom dut_i (
        .clk       (clk),
        .rst       (rst),
        .game_done (game_done),
        .game_over (game_over),
        .result    (result),
        .pos       (pos),
        .char_code (char_code)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////

    function automatic int next_rand(input int bound);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'((lcg_state >> 16) % bound);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    // text placed from column start where spaces read as blank cells
    function automatic logic [6:0] text_at(input string text, input int start, input int col);
        byte        c;
        logic [6:0] code;
        code = '0;
        if (col >= start && col < start + text.len()) begin
            c = text[col - start];
            if (c != 8'd32) begin
                code = c[6:0];
            end
        end
        return code;
    endfunction

    function automatic logic [6:0] digit_char(input int d);
        return 7'(`MEMGAME_ASCII_ZERO + d);
    endfunction

    function automatic logic [6:0] expected_char(input int row, input int col);
        logic [6:0] code;
        int         entry;
        int         value;
        code  = '0;
        entry = row - 16;
        if (row == 0) begin
            if (game_over) begin
                code = text_at("GAME OVER!", 3, col);
            end else begin
                code = text_at("Congratulations!", 1, col);
            end
        end else if (row == 2) begin
            if (col <= 11) begin
                code = text_at("Your score:", 1, col);
            end else if (col >= 13 && col <= 16) begin
                if (game_over || col <= 14) begin
                    code = digit_char(0);
                end else if (col == 15) begin
                    code = digit_char(result.pairs / 10 % 10);
                end else begin
                    code = digit_char(result.pairs % 10);
                end
            end
        end else if (row == 4) begin
            if (col <= 9) begin
                code = text_at("Your time", 1, col);
            end else if (game_over) begin
                code = text_at("passed", 11, col);
            end else if (col == 12) begin
                code = digit_char(result.seconds / 10);
            end else if (col == 13) begin
                code = digit_char(result.seconds % 10);
            end else if (col == 15) begin
                code = digit_char(result.hundredths / 10);
            end else if (col == 16) begin
                code = digit_char(result.hundredths % 10);
            end else begin
                code = text_at(":", 10, col) | text_at(".", 14, col);
            end
        end else if (row == 14) begin
            code = text_at("Highscores", 3, col);
        end else if (entry >= 0 && entry < `MEMGAME_HS_NUM) begin
            value = hs_model[entry];
            case (col)
                1: code = digit_char(entry + 1);
                2: code = text_at(".", 2, col);
                4: code = digit_char(value / 1000 % 10);
                5: code = digit_char(value / 100 % 10);
                6: code = digit_char(value / 10 % 10);
                7: code = digit_char(value % 10);
                default: code = text_at("points", 9, col);
            endcase
        end
        return code;
    endfunction

    // new score lands above the first entry it strictly beats
    function automatic void insert_score(input int score);
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < `MEMGAME_HS_NUM; i++) begin
            if (!placed && score > hs_model[i]) begin
                for (int j = `MEMGAME_HS_NUM - 1; j > i; j--) begin
                    hs_model[j] = hs_model[j-1];
                end
                hs_model[i] = score;
                placed = 1'b1;
            end
        end
    endfunction

    ////////////////////////////////////////
    // cell access and game tasks
    ////////////////////////////////////////

    // entered 1 ns after a rising edge and returns at the same phase
    task automatic sample_cell(input int row, input int col, output char_code_t code);
        pos.row = grid_idx_t'(row);
        pos.col = grid_idx_t'(col);
        @(posedge clk);
        #1;
        code = char_code;
    endtask

    task automatic read_cell(input int row, input int col);
        char_code_t code;
        sample_cell(row, col, code);
        check_value(code, expected_char(row, col), $sformatf("cell row %0d col %0d", row, col));
    endtask

    task automatic read_row(input int row);
        for (int col = 0; col < `MEMGAME_TEXT_COLS; col++) begin
            read_cell(row, col);
        end
    endtask

    task automatic read_board();
        read_row(14);
        for (int row = 16; row <= 20; row++) begin
            read_row(row);
        end
    endtask

    task automatic read_status();
        read_row(0);
        read_row(2);
        read_row(4);
    endtask

    // idle, new record, wait for new game, back to idle
    task automatic play_game(input int score);
        result.pairs = 8'(score);
        game_done = 1'b1;
        @(posedge clk);
        #1;
        @(posedge clk);
        #1;
        game_done = 1'b0;
        @(posedge clk);
        #1;
        insert_score(score);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_board();
        read_board();
    endtask

    task automatic test_normal_rows();
        game_over = 1'b0;
        for (int n = 0; n < N_RANDOM; n++) begin
            result.pairs      = 8'(next_rand(100));
            result.seconds    = 6'(next_rand(60));
            result.hundredths = 7'(next_rand(100));
            read_status();
        end
    endtask

    task automatic test_game_over_rows();
        game_over = 1'b1;
        for (int n = 0; n < N_OVER; n++) begin
            result.pairs      = 8'(next_rand(100));
            result.seconds    = 6'(next_rand(60));
            result.hundredths = 7'(next_rand(100));
            read_status();
        end
        game_over = 1'b0;
    endtask

    task automatic test_game_series();
        int score;
        for (int g = 0; g < N_GAMES; g++) begin
            if (g == 5) begin
                // tie with entry 2
                score = hs_model[2];
            end else if (g == 6) begin
                // just below the last entry
                if (hs_model[4] > 0) begin
                    score = hs_model[4] - 1;
                end else begin
                    score = 0;
                end
            end else begin
                score = next_rand(100);
            end
            play_game(score);
            read_board();
        end
    endtask

    task automatic test_held_done();
        result.pairs = 8'd200;
        game_done = 1'b1;
        @(posedge clk);
        #1;
        // only the value of the new-record cycle is taken
        result.pairs = 8'd150;
        @(posedge clk);
        #1;
        insert_score(150);
        result.pairs = 8'd250;
        for (int n = 0; n < 6; n++) begin
            @(posedge clk);
            #1;
            result.pairs = 8'(240 + n);
        end
        read_board();
        game_done = 1'b0;
        @(posedge clk);
        #1;
        play_game(120);
        read_board();
    endtask

    task automatic test_blank_cells();
        int         blank_rows [5] = '{1, 3, 15, 21, 31};
        int         text_rows [6]  = '{0, 2, 4, 14, 16, 20};
        char_code_t code;
        foreach (blank_rows[i]) begin
            for (int col = 0; col < 32; col++) begin
                sample_cell(blank_rows[i], col, code);
                check_value(code, 0, $sformatf("blank row %0d col %0d", blank_rows[i], col));
            end
        end
        foreach (text_rows[i]) begin
            for (int col = 17; col < 32; col++) begin
                sample_cell(text_rows[i], col, code);
                check_value(code, 0, $sformatf("wide column row %0d col %0d", text_rows[i], col));
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst       = 1'b1;
        game_done = 1'b0;
        game_over = 1'b0;
        result    = '0;
        pos       = '0;
        lcg_state = LCG_SEED;
        for (int i = 0; i < `MEMGAME_HS_NUM; i++) begin
            hs_model[i] = 0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value(char_code, 0, "char_code during reset");
        rst = 1'b0;

        test_reset_board();
        test_normal_rows();
        test_game_over_rows();
        test_game_series();
        test_held_done();
        test_blank_cells();

        $display("Everything OK");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
rtl/memgame_pkg.sv
rtl/highscore_table.sv
rtl/status_text.sv
rtl/score_board_text.sv
rtl/screen_char_rom.sv
tests/tb_screen_char_rom.sv
